// ==== src/lsqPkg.sv ====
// Shared sizes, widths and types for the store queue subsystem
// Queue geometry, address and data widths, access size encoding

`default_nettype none

package lsqPkg;

    // Queue geometry
    localparam int SQ_ENTRY_NUM = 8;
    localparam int SQ_PTR_WIDTH = 3;
    localparam int SQ_COUNT_WIDTH = 4;

    // Memory side
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;

    // Entry index and occupancy
    typedef logic [SQ_PTR_WIDTH-1:0] SqPtr;
    typedef logic [SQ_COUNT_WIDTH-1:0] SqCount;

    // Byte address and its word-aligned part
    typedef logic [ADDR_WIDTH-1:0] MemAddr;
    typedef logic [WORD_ADDR_WIDTH-1:0] WordAddr;

    typedef logic [DATA_WIDTH-1:0] MemData;

    // One enable per byte lane
    typedef logic [STRB_WIDTH-1:0] ByteStrobe;

    // Access size of a load or store
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } AccessSize;

endpackage

`default_nettype wire

// ==== src/lsuExecStage.sv ====
// Execute stage for one store lane and one load lane
// Registers requests, builds word address, byte strobe and lane-aligned store data

`default_nettype none

module lsuExecStage
    import lsqPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstN,
    input  wire logic      storeValid,
    input  wire SqPtr      storePtr,
    input  wire MemAddr    storeAddr,
    input  wire AccessSize storeSize,
    input  wire MemData    storeData,
    input  wire logic      loadValid,
    input  wire MemAddr    loadAddr,
    input  wire AccessSize loadSize,
    input  wire SqPtr      loadPtr,
    output logic           exeStoreValid,
    output SqPtr           exeStorePtr,
    output WordAddr        exeStoreAddr,
    output ByteStrobe      exeStoreStrb,
    output MemData         exeStoreData,
    output logic           exeLoadValid,
    output WordAddr        exeLoadAddr,
    output ByteStrobe      exeLoadStrb,
    output SqPtr           exeLoadPtr
);

    // Byte lanes touched by an access, same rule for both lanes
    function automatic ByteStrobe accessStrobe(input logic [1:0] offset, input AccessSize size);
        ByteStrobe strb;
        case (size)
            sizeByte: strb = ByteStrobe'(4'b0001 << offset);
            // Half always starts at the even lane
            sizeHalf: strb = ByteStrobe'(4'b0011 << {offset[1], 1'b0});
            default:  strb = '1;
        endcase
        return strb;
    endfunction

    function automatic logic isAligned(input logic [1:0] offset, input AccessSize size);
        return (size == sizeByte) ||
               (size == sizeHalf && !offset[0]) ||
               (size == sizeWord && offset == 2'b00);
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exeStoreValid <= 1'b0;
            exeLoadValid <= 1'b0;
        end else begin
            exeStoreValid <= storeValid;
            exeLoadValid <= loadValid;
        end
    end

    // Payload only moves with its valid
    always_ff @(posedge clk) begin
        if (storeValid) begin
            exeStorePtr <= storePtr;
            exeStoreAddr <= storeAddr[ADDR_WIDTH-1:2];
            exeStoreStrb <= accessStrobe(storeAddr[1:0], storeSize);
            exeStoreData <= storeData << {storeAddr[1:0], 3'b000};
        end
        if (loadValid) begin
            exeLoadPtr <= loadPtr;
            exeLoadAddr <= loadAddr[ADDR_WIDTH-1:2];
            exeLoadStrb <= accessStrobe(loadAddr[1:0], loadSize);
        end
    end

    // Misaligned halves and words would straddle the strobe
    assert property (@(posedge clk) disable iff (!rstN)
        storeValid |-> isAligned(storeAddr[1:0], storeSize))
        else $error("misaligned store access");

    assert property (@(posedge clk) disable iff (!rstN)
        loadValid |-> isAligned(loadAddr[1:0], loadSize))
        else $error("misaligned load access");

endmodule

`default_nettype wire

// ==== src/storeQueue.sv ====
// Circular store queue of SQ_ENTRY_NUM entries
// Allocation, execute write, retire count, head port for commit
// Store-to-load forwarding, youngest older store first

`default_nettype none

module storeQueue
    import lsqPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstN,
    input  wire logic      allocate,
    input  wire logic      exeStoreValid,
    input  wire SqPtr      exeStorePtr,
    input  wire WordAddr   exeStoreAddr,
    input  wire ByteStrobe exeStoreStrb,
    input  wire MemData    exeStoreData,
    input  wire logic      exeLoadValid,
    input  wire WordAddr   exeLoadAddr,
    input  wire ByteStrobe exeLoadStrb,
    input  wire SqPtr      exeLoadPtr,
    input  wire logic      retire,
    input  wire logic      pop,
    output logic           allocatable,
    output SqPtr           allocatedPtr,
    output SqCount         count,
    output logic           headValid,
    output WordAddr        headAddr,
    output ByteStrobe      headStrb,
    output MemData         headData,
    output logic           fwdValid,
    output logic           fwdHit,
    output logic           fwdMiss,
    output MemData         fwdData
);

    SqPtr headPtr;
    SqPtr tailPtr;
    SqCount retiredCount;
    logic allocPending;
    logic allocAccept;

    logic [SQ_ENTRY_NUM-1:0] finished;
    WordAddr addrMem [SQ_ENTRY_NUM];
    ByteStrobe strbMem [SQ_ENTRY_NUM];
    MemData dataMem [SQ_ENTRY_NUM];

    // Forwarding search
    SqPtr rangeLen;
    SqPtr scanPtr;
    SqPtr pickPtr;
    logic pickFound;

    SqPtr exeOffset;

    // Count lags the tail by a cycle, so the pending allocation is included here
    assign allocatable = (count + SqCount'(allocPending)) < SqCount'(SQ_ENTRY_NUM);
    assign allocAccept = allocate && allocatable;
    assign allocatedPtr = tailPtr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            retiredCount <= '0;
            allocPending <= 1'b0;
            finished <= '0;
        end else begin
            allocPending <= allocAccept;
            if (allocAccept) begin
                tailPtr <= tailPtr + SqPtr'(1);
                finished[tailPtr] <= 1'b0;
            end
            if (exeStoreValid) begin
                finished[exeStorePtr] <= 1'b1;
            end
            if (pop) begin
                headPtr <= headPtr + SqPtr'(1);
            end
            count <= count + SqCount'(allocPending) - SqCount'(pop);
            retiredCount <= retiredCount + SqCount'(retire) - SqCount'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (exeStoreValid) begin
            addrMem[exeStorePtr] <= exeStoreAddr;
            strbMem[exeStorePtr] <= exeStoreStrb;
            dataMem[exeStorePtr] <= exeStoreData;
        end
    end

    // Head entry goes to the committer once retired
    assign headValid = retiredCount != '0;
    assign headAddr = addrMem[headPtr];
    assign headStrb = strbMem[headPtr];
    assign headData = dataMem[headPtr];

    // Walk from head towards loadPtr; later matches overwrite earlier ones,
    // which leaves the youngest older store. Relative offsets handle the wrap.
    // loadPtr equal to head means no older store.
    always_comb begin
        rangeLen = exeLoadPtr - headPtr;
        pickFound = 1'b0;
        pickPtr = headPtr;
        scanPtr = headPtr;
        for (int r = 0; r < SQ_ENTRY_NUM; r++) begin
            scanPtr = headPtr + SqPtr'(r);
            if (SqPtr'(r) < rangeLen && finished[scanPtr] &&
                addrMem[scanPtr] == exeLoadAddr &&
                (strbMem[scanPtr] & exeLoadStrb) != '0) begin
                pickFound = 1'b1;
                pickPtr = scanPtr;
            end
        end
    end

    assign fwdValid = exeLoadValid;
    assign fwdHit = exeLoadValid && pickFound;
    // Partial cover, load needs a byte the store never wrote
    assign fwdMiss = fwdHit && ((~strbMem[pickPtr] & exeLoadStrb) != '0);
    assign fwdData = dataMem[pickPtr];

    assign exeOffset = exeStorePtr - headPtr;

    // Committer must only pop a retired head
    assert property (@(posedge clk) disable iff (!rstN)
        pop |-> headValid)
        else $error("pop without a retired head");

    // Retire in order, only executed stores
    assert property (@(posedge clk) disable iff (!rstN)
        retire |-> retiredCount < count && finished[headPtr + SqPtr'(retiredCount)])
        else $error("retire of an unexecuted or missing store");

    assert property (@(posedge clk) disable iff (!rstN)
        allocate |-> allocatable)
        else $error("allocate while full");

    assert property (@(posedge clk) disable iff (!rstN)
        exeStoreValid |-> SqCount'(exeOffset) < count + SqCount'(allocPending))
        else $error("store execute outside occupied range");

endmodule

`default_nettype wire

// ==== src/storeCommitter.sv ====
// Store committer, APB4 write master
// Takes the retired head entry, writes it, pops it on pready

`default_nettype none

module storeCommitter
    import lsqPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstN,
    input  wire logic      headValid,
    input  wire WordAddr   headAddr,
    input  wire ByteStrobe headStrb,
    input  wire MemData    headData,
    input  wire logic      pready,
    output logic           pop,
    output logic           psel,
    output logic           penable,
    output logic           pwrite,
    output MemAddr         paddr,
    output MemData         pwdata,
    output ByteStrobe      pstrb
);

    typedef enum logic [1:0] {
        stIdle,
        stSetup,
        stAccess
    } ApbState;

    ApbState state;

    // Transfer fields, held from SETUP to the end of ACCESS
    WordAddr addrReg;
    ByteStrobe strbReg;
    MemData dataReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle:   if (headValid) state <= stSetup;
                stSetup:  state <= stAccess;
                // Wait states keep us here
                stAccess: if (pready) state <= stIdle;
                default:  state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && headValid) begin
            addrReg <= headAddr;
            strbReg <= headStrb;
            dataReg <= headData;
        end
    end

    assign psel = state != stIdle;
    assign penable = state == stAccess;
    assign pwrite = 1'b1;
    assign paddr = {addrReg, 2'b00};
    assign pwdata = dataReg;
    assign pstrb = strbReg;

    // Entry released on the completing cycle
    assign pop = state == stAccess && pready;

    assert property (@(posedge clk) disable iff (!rstN)
        psel && penable && !pready |=> $stable(paddr) && $stable(pwdata) && $stable(pstrb))
        else $error("APB write fields changed during wait state");

endmodule

`default_nettype wire

// ==== src/storeQueueSys.sv ====
// Store queue subsystem top
// Execute stage, store queue and APB store committer

`default_nettype none

module storeQueueSys
    import lsqPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstN,
    // Allocation
    input  wire logic      allocate,
    output logic           allocatable,
    output SqPtr           allocatedPtr,
    output SqCount         count,
    // Store and load requests
    input  wire logic      storeValid,
    input  wire SqPtr      storePtr,
    input  wire MemAddr    storeAddr,
    input  wire AccessSize storeSize,
    input  wire MemData    storeData,
    input  wire logic      loadValid,
    input  wire MemAddr    loadAddr,
    input  wire AccessSize loadSize,
    input  wire SqPtr      loadPtr,
    input  wire logic      retire,
    // Forwarding result
    output logic           fwdValid,
    output logic           fwdHit,
    output logic           fwdMiss,
    output MemData         fwdData,
    // Commit status
    output logic           headValid,
    output logic           pop,
    // APB4 master
    output logic           psel,
    output logic           penable,
    output logic           pwrite,
    output MemAddr         paddr,
    output MemData         pwdata,
    output ByteStrobe      pstrb,
    input  wire logic      pready
);

    logic exeStoreValid;
    SqPtr exeStorePtr;
    WordAddr exeStoreAddr;
    ByteStrobe exeStoreStrb;
    MemData exeStoreData;
    logic exeLoadValid;
    WordAddr exeLoadAddr;
    ByteStrobe exeLoadStrb;
    SqPtr exeLoadPtr;

    WordAddr headAddr;
    ByteStrobe headStrb;
    MemData headData;

    lsuExecStage lsuExecStage_inst (
        .clk(clk),
        .rstN(rstN),
        .storeValid(storeValid),
        .storePtr(storePtr),
        .storeAddr(storeAddr),
        .storeSize(storeSize),
        .storeData(storeData),
        .loadValid(loadValid),
        .loadAddr(loadAddr),
        .loadSize(loadSize),
        .loadPtr(loadPtr),
        .exeStoreValid(exeStoreValid),
        .exeStorePtr(exeStorePtr),
        .exeStoreAddr(exeStoreAddr),
        .exeStoreStrb(exeStoreStrb),
        .exeStoreData(exeStoreData),
        .exeLoadValid(exeLoadValid),
        .exeLoadAddr(exeLoadAddr),
        .exeLoadStrb(exeLoadStrb),
        .exeLoadPtr(exeLoadPtr)
    );

    storeQueue storeQueue_inst (
        .clk(clk),
        .rstN(rstN),
        .allocate(allocate),
        .exeStoreValid(exeStoreValid),
        .exeStorePtr(exeStorePtr),
        .exeStoreAddr(exeStoreAddr),
        .exeStoreStrb(exeStoreStrb),
        .exeStoreData(exeStoreData),
        .exeLoadValid(exeLoadValid),
        .exeLoadAddr(exeLoadAddr),
        .exeLoadStrb(exeLoadStrb),
        .exeLoadPtr(exeLoadPtr),
        .retire(retire),
        .pop(pop),
        .allocatable(allocatable),
        .allocatedPtr(allocatedPtr),
        .count(count),
        .headValid(headValid),
        .headAddr(headAddr),
        .headStrb(headStrb),
        .headData(headData),
        .fwdValid(fwdValid),
        .fwdHit(fwdHit),
        .fwdMiss(fwdMiss),
        .fwdData(fwdData)
    );

    storeCommitter storeCommitter_inst (
        .clk(clk),
        .rstN(rstN),
        .headValid(headValid),
        .headAddr(headAddr),
        .headStrb(headStrb),
        .headData(headData),
        .pready(pready),
        .pop(pop),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .pstrb(pstrb)
    );

endmodule

`default_nettype wire

// ==== tb/tbStoreQueueSys.sv ====
// Testbench for the store queue subsystem
// Step table of allocations, stores, loads and retires, APB slave memory model
// with random wait states, compare tasks and timeouts

`default_nettype none

module tbStoreQueueSys
    import lsqPkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;

    typedef enum logic [2:0] {opAlloc, opFull, opStore, opLoad, opRetire, opDrain} StepKind;

    // ptr is the expected alloc pointer, the store pointer or the load pointer
    typedef struct packed {
        StepKind kind;
        SqPtr ptr;
        MemAddr addr;
        AccessSize size;
        MemData data;
        logic expHit;
        logic expMiss;
    } Step;

    logic clk = 1'b0;
    logic rstN;
    logic allocate, allocatable, retire, headValid, pop;
    SqPtr allocatedPtr;
    SqCount count;
    logic storeValid, loadValid;
    SqPtr storePtr, loadPtr;
    MemAddr storeAddr, loadAddr;
    AccessSize storeSize, loadSize;
    MemData storeData;
    logic fwdValid, fwdHit, fwdMiss;
    MemData fwdData;
    logic psel, penable, pwrite;
    logic pready = 1'b0;
    MemAddr paddr;
    MemData pwdata;
    ByteStrobe pstrb;

    integer seed = 32'he6685edf;
    int waitLeft = 0;

    Step steps[$];
    // Writes the memory should see, in commit order
    MemAddr expWrAddr[$];
    ByteStrobe expWrStrb[$];
    MemData expWrData[$];
    // Expected write of each executed entry
    MemAddr wrAddrByPtr[SQ_ENTRY_NUM];
    ByteStrobe wrStrbByPtr[SQ_ENTRY_NUM];
    MemData wrDataByPtr[SQ_ENTRY_NUM];
    SqPtr retirePtr = '0;
    // Allocations and retires issued so far
    int allocTotal = 0;
    int retireTotal = 0;

    always #50 clk = ~clk;

    storeQueueSys storeQueueSys_inst (
        .clk(clk),
        .rstN(rstN),
        .allocate(allocate),
        .allocatable(allocatable),
        .allocatedPtr(allocatedPtr),
        .count(count),
        .storeValid(storeValid),
        .storePtr(storePtr),
        .storeAddr(storeAddr),
        .storeSize(storeSize),
        .storeData(storeData),
        .loadValid(loadValid),
        .loadAddr(loadAddr),
        .loadSize(loadSize),
        .loadPtr(loadPtr),
        .retire(retire),
        .fwdValid(fwdValid),
        .fwdHit(fwdHit),
        .fwdMiss(fwdMiss),
        .fwdData(fwdData),
        .headValid(headValid),
        .pop(pop),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .pstrb(pstrb),
        .pready(pready)
    );

    task automatic abortRun();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkPtr(input string name, input SqPtr got, input SqPtr exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input SqCount got, input SqCount exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkStrb(input string name, input ByteStrobe got, input ByteStrobe exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkData(input string name, input MemData got, input MemData exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkAddr(input string name, input MemAddr got, input MemAddr exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    // Byte lanes of an access: one lane, an even lane pair, or the whole word
    function automatic ByteStrobe laneMask(input logic [1:0] offset, input AccessSize size);
        case (size)
            sizeByte: return ByteStrobe'(4'b0001 << offset);
            sizeHalf: return offset[1] ? 4'b1100 : 4'b0011;
            default:  return 4'b1111;
        endcase
    endfunction

    function automatic logic commitsPending();
        return expWrAddr.size() != 0 || headValid || psel;
    endfunction

    task automatic addStep(input StepKind kind, input SqPtr ptr, input MemAddr addr,
                           input AccessSize size, input MemData data,
                           input logic hit, input logic miss);
        Step s;
        s = '{kind, ptr, addr, size, data, hit, miss};
        steps.push_back(s);
    endtask

    task automatic waitAllocatable();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!allocatable && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!allocatable) begin
            $display("Timeout: allocatable stayed low for %0d cycles", TIMEOUT_CYCLES);
            abortRun();
        end
    endtask

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (commitsPending() && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (commitsPending()) begin
            $display("Timeout: retired stores not written to memory in %0d cycles",
                     TIMEOUT_CYCLES);
            abortRun();
        end
    endtask

    task automatic applyStep(input Step s);
        case (s.kind)
            opAlloc: begin
                waitAllocatable();
                allocTotal++;
                @(posedge clk);
                allocate <= 1'b1;
                @(negedge clk);
                checkPtr("allocatedPtr", allocatedPtr, s.ptr);
                @(posedge clk);
                allocate <= 1'b0;
            end
            opFull: begin
                @(negedge clk);
                checkFlag("allocatable", allocatable, 1'b0);
            end
            opStore: begin
                wrAddrByPtr[s.ptr] = {s.addr[ADDR_WIDTH-1:2], 2'b00};
                wrStrbByPtr[s.ptr] = laneMask(s.addr[1:0], s.size);
                wrDataByPtr[s.ptr] = s.data << (8 * int'(s.addr[1:0]));
                @(posedge clk);
                storeValid <= 1'b1;
                storePtr <= s.ptr;
                storeAddr <= s.addr;
                storeSize <= s.size;
                storeData <= s.data;
                @(posedge clk);
                storeValid <= 1'b0;
            end
            opLoad: begin
                @(posedge clk);
                loadValid <= 1'b1;
                loadPtr <= s.ptr;
                loadAddr <= s.addr;
                loadSize <= s.size;
                @(posedge clk);
                loadValid <= 1'b0;
                // Answer belongs to the cycle after loadValid
                @(negedge clk);
                checkFlag("fwdValid", fwdValid, 1'b1);
                checkFlag("fwdHit", fwdHit, s.expHit);
                checkFlag("fwdMiss", fwdMiss, s.expMiss);
                if (s.expHit) begin
                    checkData("fwdData", fwdData, s.data);
                end
            end
            opRetire: begin
                expWrAddr.push_back(wrAddrByPtr[retirePtr]);
                expWrStrb.push_back(wrStrbByPtr[retirePtr]);
                expWrData.push_back(wrDataByPtr[retirePtr]);
                retirePtr = retirePtr + SqPtr'(1);
                retireTotal++;
                @(posedge clk);
                retire <= 1'b1;
                @(posedge clk);
                retire <= 1'b0;
            end
            default: begin
                waitDrained();
                // Every retired store is written and released by now
                checkCount("count", count, SqCount'(allocTotal - retireTotal));
            end
        endcase
    endtask

    task automatic buildTable();
        // Fill the queue, then it must report full
        for (int i = 0; i < SQ_ENTRY_NUM; i++) begin
            addStep(opAlloc, SqPtr'(i), '0, sizeWord, '0, 1'b0, 1'b0);
        end
        addStep(opFull, 3'd0, '0, sizeWord, '0, 1'b0, 1'b0);
        addStep(opStore, 3'd0, 32'h100, sizeWord, 32'h11223344, 1'b0, 1'b0);
        addStep(opStore, 3'd1, 32'h101, sizeByte, 32'h000000AA, 1'b0, 1'b0);
        addStep(opStore, 3'd2, 32'h106, sizeHalf, 32'h0000BEEF, 1'b0, 1'b0);
        addStep(opStore, 3'd3, 32'h104, sizeWord, 32'h55667788, 1'b0, 1'b0);
        addStep(opStore, 3'd4, 32'h200, sizeByte, 32'h0000005A, 1'b0, 1'b0);
        // Entry 5 not executed yet
        addStep(opLoad, 3'd6, 32'h300, sizeWord, '0, 1'b0, 1'b0);
        addStep(opLoad, 3'd1, 32'h100, sizeWord, 32'h11223344, 1'b1, 1'b0);
        addStep(opLoad, 3'd2, 32'h100, sizeWord, 32'h0000AA00, 1'b1, 1'b1);
        addStep(opLoad, 3'd4, 32'h104, sizeWord, 32'h55667788, 1'b1, 1'b0);
        addStep(opLoad, 3'd5, 32'h400, sizeWord, '0, 1'b0, 1'b0);
        addStep(opLoad, 3'd5, 32'h200, sizeWord, 32'h0000005A, 1'b1, 1'b1);
        addStep(opStore, 3'd5, 32'h300, sizeWord, 32'hCAFEF00D, 1'b0, 1'b0);
        addStep(opStore, 3'd6, 32'h302, sizeHalf, 32'h00001234, 1'b0, 1'b0);
        addStep(opStore, 3'd7, 32'h300, sizeByte, 32'h00000077, 1'b0, 1'b0);
        repeat (5) addStep(opRetire, 3'd0, '0, sizeWord, '0, 1'b0, 1'b0);
        addStep(opDrain, 3'd0, '0, sizeWord, '0, 1'b0, 1'b0);
        // Head now at 5, the tail wraps to 0 and 1
        addStep(opAlloc, 3'd0, '0, sizeWord, '0, 1'b0, 1'b0);
        addStep(opAlloc, 3'd1, '0, sizeWord, '0, 1'b0, 1'b0);
        // Entries 0 and 1 still hold old 0x100 stores but are not executed again
        addStep(opLoad, 3'd2, 32'h100, sizeWord, '0, 1'b0, 1'b0);
        addStep(opStore, 3'd0, 32'h302, sizeHalf, 32'h0000D00D, 1'b0, 1'b0);
        addStep(opStore, 3'd1, 32'h304, sizeWord, 32'h9999AAAA, 1'b0, 1'b0);
        addStep(opLoad, 3'd1, 32'h300, sizeWord, 32'hD00D0000, 1'b1, 1'b1);
        addStep(opLoad, 3'd1, 32'h300, sizeByte, 32'h00000077, 1'b1, 1'b0);
        addStep(opLoad, 3'd0, 32'h302, sizeHalf, 32'h12340000, 1'b1, 1'b0);
        repeat (5) addStep(opRetire, 3'd0, '0, sizeWord, '0, 1'b0, 1'b0);
        addStep(opDrain, 3'd0, '0, sizeWord, '0, 1'b0, 1'b0);
    endtask

    // APB slave, 0 to 3 wait states per transfer
    always @(posedge clk) begin : apbSlave
        int picked;
        if (!rstN) begin
            pready <= 1'b0;
            waitLeft <= 0;
        end else if (psel && !penable) begin
            picked = $random(seed) & 3;
            waitLeft <= picked;
            pready <= (picked == 0);
        end else if (psel && penable && !pready) begin
            waitLeft <= waitLeft - 1;
            pready <= (waitLeft == 1);
        end else begin
            pready <= 1'b0;
        end
    end

    // Memory side check of each completed write
    always @(negedge clk) begin
        if (rstN && psel && penable && pready) begin
            if (expWrAddr.size() == 0) begin
                $display("APB write at %0t with no retired store waiting for it", $time);
                abortRun();
            end
            checkFlag("pwrite", pwrite, 1'b1);
            checkFlag("pop", pop, 1'b1);
            checkAddr("paddr", paddr, expWrAddr.pop_front());
            checkStrb("pstrb", pstrb, expWrStrb.pop_front());
            checkData("pwdata", pwdata, expWrData.pop_front());
        end
    end

    initial begin
        rstN <= 1'b0;
        allocate <= 1'b0;
        retire <= 1'b0;
        storeValid <= 1'b0;
        storePtr <= '0;
        storeAddr <= '0;
        storeSize <= sizeWord;
        storeData <= '0;
        loadValid <= 1'b0;
        loadPtr <= '0;
        loadAddr <= '0;
        loadSize <= sizeWord;
        buildTable();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkFlag("allocatable", allocatable, 1'b1);
        checkFlag("headValid", headValid, 1'b0);
        checkFlag("psel", psel, 1'b0);
        checkFlag("penable", penable, 1'b0);
        checkFlag("pop", pop, 1'b0);
        checkFlag("fwdValid", fwdValid, 1'b0);
        for (int i = 0; i < steps.size(); i++) begin
            applyStep(steps[i]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== storeQueueSys.f ====
src/lsqPkg.sv
src/lsuExecStage.sv
src/storeQueue.sv
src/storeCommitter.sv
src/storeQueueSys.sv
tb/tbStoreQueueSys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the store queue testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tbStoreQueueSys \
    -f storeQueueSys.f -o simStoreQueueSys > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simStoreQueueSys > sim.log 2>&1
cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
